// ==== logic/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    localparam int TLB_ENTRIES          = 4;
    localparam int TLB_IDX_W            = 2;
    localparam int RESET_STRETCH_CYCLES = 16;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } acc_size_t;

    // MIPS ExcCode subset seen on the data port
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5
    } exc_code_t;

    typedef struct packed {
        vaddr_t    vaddr;
        logic      write;
        acc_size_t size;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        exc_code_t   exc;
    } cpu_resp_t;

    typedef struct packed {
        logic [19:0] vpn;
        logic [19:0] pfn;
        logic        valid;
        logic        dirty;
    } tlb_entry_t;

    typedef struct packed {
        logic        hit;
        logic        valid;
        logic        dirty;
        logic [19:0] pfn;
    } tlb_result_t;

    typedef struct packed {
        logic        we;
        paddr_t      addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/reset_stretch.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_stretch (
    input  wire  aclk,
    input  wire  aresetn,
    output logic o_rst_n
);
    import mmu_pkg::*;

    localparam int CNT_W = $clog2(RESET_STRETCH_CYCLES);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cnt     <= '0;
            o_rst_n <= 1'b0;
        end else if (!o_rst_n) begin
            if (cnt == CNT_W'(RESET_STRETCH_CYCLES - 1)) begin
                o_rst_n <= 1'b1;                // stretch done
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // internal reset drops together with the external one
    a_rst_follows: assert property (@(posedge aclk) !aresetn |=> !o_rst_n);

endmodule

`default_nettype wire

// ==== logic/tlb_lookup.sv ====
`timescale 1ns/100ps
`default_nettype none

module tlb_lookup (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire                          i_rst_n,
    input  wire                          i_we,
    input  wire [mmu_pkg::TLB_IDX_W-1:0] i_idx,
    input  wire mmu_pkg::tlb_entry_t     i_entry,
    input  wire [19:0]                   i_vpn,
    output mmu_pkg::tlb_result_t         o_result
);
    import mmu_pkg::*;

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] filled;                 // entry written since reset
    logic [TLB_ENTRIES-1:0] match;

    // entry contents, written whole
    always_ff @(posedge aclk) begin
        if (i_we) begin
            entries[i_idx] <= i_entry;
        end
    end

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            filled <= '0;                           // all entries read as invalid
        end else if (i_we) begin
            filled[i_idx] <= 1'b1;
        end
    end

    // parallel vpn compare
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = filled[i] && (entries[i].vpn == i_vpn);
        end
    end

    always_comb begin
        o_result = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                o_result.hit   = 1'b1;
                o_result.valid = entries[i].valid;
                o_result.dirty = entries[i].dirty;
                o_result.pfn   = entries[i].pfn;
            end
        end
    end

    // software must never load two entries with the same vpn
    a_one_match: assert property (
        @(posedge aclk) disable iff (!aresetn) $onehot0(match)
    );

endmodule

`default_nettype wire

// ==== logic/mem_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl (
    input  wire                       aclk,
    input  wire                       i_rst_n,
    input  wire                       i_req,
    input  wire mmu_pkg::cpu_req_t    i_cpu_req,
    input  wire                       i_kernel_mode,
    output logic                      o_ack,
    output mmu_pkg::cpu_resp_t        o_cpu_resp,
    output logic [19:0]               o_vpn,
    input  wire mmu_pkg::tlb_result_t i_tlb,
    output logic                      o_bus_start,
    output mmu_pkg::mem_req_t         o_bus_req,
    output mmu_pkg::acc_size_t        o_bus_size,
    input  wire                       i_bus_done,
    input  wire mmu_pkg::paddr_t      i_bus_rdata
);
    import mmu_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_CHECK, S_BUS, S_RESP, S_REL} state_t;

    state_t    state;
    cpu_req_t  req_q;
    logic      kmode_q;
    exc_code_t exc_q;
    paddr_t    pa_q;
    logic      start_q;
    vaddr_t    va;
    logic      kuseg;
    logic      misalign;
    logic      addr_err;
    exc_code_t exc_d;
    paddr_t    pa_d;

    assign va       = req_q.vaddr;
    assign kuseg    = ~va[31];
    assign misalign = (req_q.size == SIZE_HALF && va[0]) ||
                      (req_q.size == SIZE_WORD && va[1:0] != 2'b00);
    // user access above 2G, and kseg2/kseg3 which are not mapped here
    assign addr_err = misalign || (!kmode_q && va[31]) || (va[31:30] == 2'b11);

    always_comb begin
        if (addr_err) begin
            exc_d = req_q.write ? EXC_ADES : EXC_ADEL;
        end else if (kuseg && !(i_tlb.hit && i_tlb.valid)) begin
            exc_d = req_q.write ? EXC_TLBS : EXC_TLBL;
        end else if (kuseg && req_q.write && !i_tlb.dirty) begin
            exc_d = EXC_MOD;
        end else begin
            exc_d = EXC_NONE;
        end
    end

    assign pa_d = kuseg ? {i_tlb.pfn, va[11:0]} : {3'b000, va[28:0]};

    always_ff @(posedge aclk) begin
        if (state == S_IDLE && i_req) begin
            req_q   <= i_cpu_req;
            kmode_q <= i_kernel_mode;
        end
        if (state == S_CHECK) begin
            exc_q <= exc_d;
            pa_q  <= pa_d;
        end
        if (state == S_BUS && i_bus_done) begin
            o_cpu_resp <= '{rdata: req_q.write ? 32'h0 : i_bus_rdata, exc: EXC_NONE};
        end
        if (state == S_RESP) begin
            o_cpu_resp <= '{rdata: 32'h0, exc: exc_q};
        end
    end

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            state   <= S_IDLE;
            o_ack   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                S_IDLE:  if (i_req) state <= S_CHECK;
                S_CHECK: begin
                    if (exc_d == EXC_NONE) begin
                        start_q <= 1'b1;        // single-cycle kick to the bus master
                        state   <= S_BUS;
                    end else begin
                        state <= S_RESP;
                    end
                end
                S_BUS: begin
                    if (i_bus_done) begin
                        o_ack <= 1'b1;
                        state <= S_REL;
                    end
                end
                S_RESP: begin
                    o_ack <= 1'b1;
                    state <= S_REL;
                end
                S_REL: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;          // four-phase return to zero
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign o_vpn       = req_q.vaddr[31:12];
    assign o_bus_start = start_q;
    assign o_bus_size  = req_q.size;
    assign o_bus_req   = '{we: req_q.write, addr: pa_q, strb: 4'b0000, wdata: req_q.wdata};

    // a faulting access must never reach memory
    a_no_bus_on_exc: assert property (
        @(posedge aclk) disable iff (!i_rst_n) o_bus_start |-> exc_q == EXC_NONE
    );

endmodule

`default_nettype wire

// ==== logic/bus_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_master (
    input  wire                     aclk,
    input  wire                     i_rst_n,
    input  wire                     i_start,
    input  wire mmu_pkg::mem_req_t  i_req,
    input  wire mmu_pkg::acc_size_t i_size,
    output logic                    o_done,
    output mmu_pkg::paddr_t         o_rdata,
    output logic                    o_mem_req,
    output mmu_pkg::mem_req_t       o_mem_req_bus,
    input  wire                     i_mem_ack,
    input  wire mmu_pkg::paddr_t    i_mem_rdata
);
    import mmu_pkg::*;

    typedef enum logic [1:0] {B_IDLE, B_REQ, B_DROP} bstate_t;

    bstate_t     state;
    acc_size_t   size_q;
    logic [3:0]  strb_d;
    logic [31:0] wdata_d;
    paddr_t      shifted;
    paddr_t      rdata_ext;

    // lane select and write data replication
    always_comb begin
        case (i_size)
            SIZE_BYTE: begin
                strb_d  = 4'b0001 << i_req.addr[1:0];
                wdata_d = {4{i_req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                strb_d  = i_req.addr[1] ? 4'b1100 : 4'b0011;
                wdata_d = {2{i_req.wdata[15:0]}};
            end
            default: begin
                strb_d  = 4'b1111;
                wdata_d = i_req.wdata;
            end
        endcase
    end

    assign shifted = i_mem_rdata >> {o_mem_req_bus.addr[1:0], 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: rdata_ext = {24'h0, shifted[7:0]};
            SIZE_HALF: rdata_ext = {16'h0, shifted[15:0]};
            default:   rdata_ext = shifted;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (state == B_IDLE && i_start) begin
            o_mem_req_bus <= '{we: i_req.we, addr: i_req.addr, strb: strb_d, wdata: wdata_d};
            size_q        <= i_size;
        end
        if (state == B_REQ && i_mem_ack) begin
            o_rdata <= rdata_ext;               // zero-extended from lane 0
        end
    end

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            state     <= B_IDLE;
            o_mem_req <= 1'b0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (i_start) begin
                        o_mem_req <= 1'b1;
                        state     <= B_REQ;
                    end
                end
                B_REQ: begin
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        state     <= B_DROP;
                    end
                end
                B_DROP: begin
                    if (!i_mem_ack) begin
                        o_done <= 1'b1;         // memory has released ack
                        state  <= B_IDLE;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    a_bus_stable: assert property (
        @(posedge aclk) disable iff (!i_rst_n)
        o_mem_req && $past(o_mem_req) |-> $stable(o_mem_req_bus)
    );

endmodule

`default_nettype wire

// ==== logic/mmu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmu_top (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire                          i_req,
    input  wire mmu_pkg::cpu_req_t       i_cpu_req,
    input  wire                          i_kernel_mode,
    output logic                         o_ack,
    output mmu_pkg::cpu_resp_t           o_cpu_resp,
    input  wire                          i_tlb_we,
    input  wire [mmu_pkg::TLB_IDX_W-1:0] i_tlb_idx,
    input  wire mmu_pkg::tlb_entry_t     i_tlb_entry,
    output logic                         o_mem_req,
    output mmu_pkg::mem_req_t            o_mem_req_bus,
    input  wire                          i_mem_ack,
    input  wire mmu_pkg::paddr_t         i_mem_rdata
);
    import mmu_pkg::*;

    logic        rst_n_int;
    logic [19:0] vpn;
    tlb_result_t tlb_res;
    logic        bus_start;
    mem_req_t    bus_req;
    acc_size_t   bus_size;
    logic        bus_done;
    paddr_t      bus_rdata;

    reset_stretch u_rst (
        .aclk    (aclk),
        .aresetn (aresetn),
        .o_rst_n (rst_n_int)
    );

    tlb_lookup u_tlb (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .i_rst_n  (rst_n_int),
        .i_we     (i_tlb_we),
        .i_idx    (i_tlb_idx),
        .i_entry  (i_tlb_entry),
        .i_vpn    (vpn),
        .o_result (tlb_res)
    );

    mem_ctrl u_ctrl (
        .aclk          (aclk),
        .i_rst_n       (rst_n_int),
        .i_req         (i_req),
        .i_cpu_req     (i_cpu_req),
        .i_kernel_mode (i_kernel_mode),
        .o_ack         (o_ack),
        .o_cpu_resp    (o_cpu_resp),
        .o_vpn         (vpn),
        .i_tlb         (tlb_res),
        .o_bus_start   (bus_start),
        .o_bus_req     (bus_req),
        .o_bus_size    (bus_size),
        .i_bus_done    (bus_done),
        .i_bus_rdata   (bus_rdata)
    );

    bus_master u_bus (
        .aclk          (aclk),
        .i_rst_n       (rst_n_int),
        .i_start       (bus_start),
        .i_req         (bus_req),
        .i_size        (bus_size),
        .o_done        (bus_done),
        .o_rdata       (bus_rdata),
        .o_mem_req     (o_mem_req),
        .o_mem_req_bus (o_mem_req_bus),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model (
    input  wire                    aclk,
    input  wire                    aresetn,
    input  wire                    i_req,
    input  wire mmu_pkg::mem_req_t i_bus,
    input  wire [1:0]              i_delay,
    output logic                   o_ack,
    output mmu_pkg::paddr_t        o_rdata,
    output int                     o_errs
);
    import mmu_pkg::*;

    logic [7:0]  mem_bytes [logic [31:0]];
    logic [31:0] rd_word;

    // unwritten bytes read back as a mix of every address byte
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    task automatic serve_lanes();
        logic [31:0] a;
        for (int i = 0; i < 4; i++) begin
            a = {i_bus.addr[31:2], 2'(i)};
            if (i_bus.we && i_bus.strb[i]) begin
                mem_bytes[a] = i_bus.wdata[8*i +: 8];
            end
            rd_word[8*i +: 8] = mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
        end
    endtask

    task automatic protocol_error(input string what);
        o_errs++;
        $display("%0t ns: memory protocol broken, %s", $time, what);
    endtask

    initial begin
        int wait_cnt;
        wait_cnt = 0;
        o_errs   = 0;
        o_ack    = 1'b0;
        o_rdata  = '0;
        forever begin
            @(posedge aclk);
            if (!aresetn) begin
                o_ack <= 1'b0;
                wait_cnt = 0;
            end else if (!o_ack && i_req) begin
                if (wait_cnt == int'(i_delay)) begin   // ack delay reached
                    serve_lanes();
                    o_rdata <= rd_word;
                    o_ack   <= 1'b1;
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end else if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
        end
    end

    a_req_held: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req && !o_ack |=> i_req)
        else protocol_error("request withdrawn before ack");
    a_req_drop: assert property (@(posedge aclk) disable iff (!aresetn)
        $fell(i_req) |-> o_ack)
        else protocol_error("request dropped without ack");
    a_new_req: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(i_req) |-> !o_ack)
        else protocol_error("new request while ack still high");
    a_bus_held: assert property (@(posedge aclk) disable iff (!aresetn)
        i_req && $past(i_req) |-> $stable(i_bus))
        else protocol_error("request bus changed while request high");

endmodule

`default_nettype wire

// ==== verif/tb_mmu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mmu_top;
    import mmu_pkg::*;

    localparam int ACK_TIMEOUT = 200;      // negedges

    logic                   aclk;
    logic                   aresetn;
    logic                   i_req;
    cpu_req_t               i_cpu_req;
    logic                   i_kernel_mode;
    logic                   o_ack;
    cpu_resp_t              o_cpu_resp;
    logic                   i_tlb_we;
    logic [TLB_IDX_W-1:0]   i_tlb_idx;
    tlb_entry_t             i_tlb_entry;
    logic                   o_mem_req;
    mem_req_t               o_mem_req_bus;
    logic                   i_mem_ack;
    paddr_t                 i_mem_rdata;
    logic [1:0]             mem_delay;
    int                     mem_errs;

    logic [31:0]            lfsr_q;
    logic [7:0]             ref_mem [logic [31:0]];
    tlb_entry_t             tlb_copy [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] tlb_set;
    cpu_resp_t              exp_resp;
    mem_req_t               exp_bus;
    logic                   mem_expected;
    int                     hi_edges;           // edges seen with aresetn high
    int                     n_err;
    int                     n_pass;
    int                     n_fail;

    mmu_top u_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_req         (i_req),
        .i_cpu_req     (i_cpu_req),
        .i_kernel_mode (i_kernel_mode),
        .o_ack         (o_ack),
        .o_cpu_resp    (o_cpu_resp),
        .i_tlb_we      (i_tlb_we),
        .i_tlb_idx     (i_tlb_idx),
        .i_tlb_entry   (i_tlb_entry),
        .o_mem_req     (o_mem_req),
        .o_mem_req_bus (o_mem_req_bus),
        .i_mem_ack     (i_mem_ack),
        .i_mem_rdata   (i_mem_rdata)
    );

    mem_model u_mem (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_req   (o_mem_req),
        .i_bus   (o_mem_req_bus),
        .i_delay (mem_delay),
        .o_ack   (i_mem_ack),
        .o_rdata (i_mem_rdata),
        .o_errs  (mem_errs)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (aresetn) begin
            hi_edges <= hi_edges + 1;
        end
    end

    task automatic note_error(input string msg);
        n_err++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    function automatic int err_total();
        return n_err + mem_errs;
    endfunction

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // no ack stays high or memory request goes out until the stretch is over
    a_quiet_stretch: assert property (@(posedge aclk) disable iff (!aresetn)
        (hi_edges <= RESET_STRETCH_CYCLES + 2) |-> !o_ack && !o_mem_req)
        else note_error("o_ack or o_mem_req high during the reset stretch");
    a_resp: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(o_ack) |-> o_cpu_resp == exp_resp)
        else note_error($sformatf("response rdata %h exc %0d, expected rdata %h exc %0d",
            o_cpu_resp.rdata, o_cpu_resp.exc, exp_resp.rdata, exp_resp.exc));
    a_bus: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(o_mem_req) |-> o_mem_req_bus.we == exp_bus.we &&
            o_mem_req_bus.addr == exp_bus.addr && o_mem_req_bus.strb == exp_bus.strb &&
            (!exp_bus.we || o_mem_req_bus.wdata == exp_bus.wdata))
        else note_error($sformatf("memory request we %b addr %h strb %b, expected %b %h %b",
            o_mem_req_bus.we, o_mem_req_bus.addr, o_mem_req_bus.strb,
            exp_bus.we, exp_bus.addr, exp_bus.strb));
    a_no_mem: assert property (@(posedge aclk) disable iff (!aresetn)
        !mem_expected |-> !o_mem_req)
        else note_error("memory request issued for a faulting access");
    a_ack_rise: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(o_ack) |-> i_req)
        else note_error("o_ack rose without i_req");
    a_ack_fall: assert property (@(posedge aclk) disable iff (!aresetn)
        $fell(o_ack) |-> !$past(i_req))
        else note_error("o_ack fell while i_req still high");

    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level, input string what);
        int t;
        t = 0;
        @(negedge aclk);
        while (o_ack !== level && t < ACK_TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (o_ack !== level) begin
            abort_run($sformatf("timeout, o_ack never went to %0b while %s", level, what));
        end
    endtask

    // expected response and memory request, from the translation rules
    task automatic predict(input cpu_req_t rq, input logic km);
        logic       fault;
        logic       hit;
        tlb_entry_t ent;
        paddr_t     pa;
        exc_code_t  exc;
        int         nb;
        fault = (rq.size == SIZE_HALF && rq.vaddr[0]) ||
                (rq.size == SIZE_WORD && rq.vaddr[1:0] != 2'b00) ||
                (!km && rq.vaddr[31]) || (rq.vaddr[31:30] == 2'b11);
        hit = 1'b0;
        ent = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (tlb_set[i] && tlb_copy[i].vpn == rq.vaddr[31:12]) begin
                hit = 1'b1;
                ent = tlb_copy[i];
            end
        end
        exc = EXC_NONE;
        if (fault) begin
            exc = rq.write ? EXC_ADES : EXC_ADEL;
        end else if (!rq.vaddr[31] && !(hit && ent.valid)) begin
            exc = rq.write ? EXC_TLBS : EXC_TLBL;
        end else if (!rq.vaddr[31] && rq.write && !ent.dirty) begin
            exc = EXC_MOD;
        end
        pa = rq.vaddr[31] ? {3'b000, rq.vaddr[28:0]} : {ent.pfn, rq.vaddr[11:0]};
        case (rq.size)
            SIZE_BYTE: begin
                nb            = 1;
                exp_bus.strb  = 4'b0001 << pa[1:0];
                exp_bus.wdata = {4{rq.wdata[7:0]}};
            end
            SIZE_HALF: begin
                nb            = 2;
                exp_bus.strb  = 4'b0011 << pa[1:0];
                exp_bus.wdata = {2{rq.wdata[15:0]}};
            end
            default: begin
                nb            = 4;
                exp_bus.strb  = 4'b1111;
                exp_bus.wdata = rq.wdata;
            end
        endcase
        exp_bus.we   = rq.write;
        exp_bus.addr = pa;
        exp_resp     = '{rdata: 32'h0, exc: exc};
        mem_expected = (exc == EXC_NONE);
        for (int i = 0; i < nb; i++) begin
            if (mem_expected && rq.write) begin
                ref_mem[pa + 32'(i)] = rq.wdata[8*i +: 8];
            end else if (mem_expected) begin
                exp_resp.rdata[8*i +: 8] = ref_mem[pa + 32'(i)];
            end
        end
    endtask

    task automatic cpu_access(input vaddr_t va, input logic wr, input acc_size_t sz,
                              input logic [31:0] wd, input logic km);
        cpu_req_t rq;
        rq = '{vaddr: va, write: wr, size: sz, wdata: wd};
        predict(rq, km);
        @(posedge aclk);
        i_cpu_req     <= rq;
        i_kernel_mode <= km;
        i_req         <= 1'b1;
        mem_delay     <= 2'(lfsr_take(2));
        wait_ack(1'b1, $sformatf("waiting for the response to %h", va));
        @(posedge aclk);
        i_req <= 1'b0;
        wait_ack(1'b0, $sformatf("waiting for the release of %h", va));
    endtask

    task automatic tlb_write(input int idx, input logic [19:0] vpn, input logic [19:0] pfn,
                             input logic v, input logic d);
        tlb_entry_t e;
        e = '{vpn: vpn, pfn: pfn, valid: v, dirty: d};
        @(posedge aclk);
        i_tlb_we    <= 1'b1;
        i_tlb_idx   <= TLB_IDX_W'(idx);
        i_tlb_entry <= e;
        tlb_copy[idx] = e;
        tlb_set[idx]  = 1'b1;
        @(posedge aclk);
        i_tlb_we <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int e0);
        repeat (2) @(posedge aclk);        // let trailing assertions fire
        if (err_total() == e0) begin
            n_pass++;
            $display("%s: passed", name);
        end else begin
            n_fail++;
            $display("%s: failed with %0d errors", name, err_total() - e0);
        end
    endtask

    task automatic test_unmapped();
        int     e0;
        vaddr_t base;
        e0   = err_total();
        base = 32'h0000_1000 | ((lfsr_take(8) & 32'h0000_00ff) << 4);
        cpu_access(32'hA000_0000 | base, 1'b1, SIZE_WORD, lfsr_take(32), 1'b1);
        cpu_access(32'hA000_0001 | base, 1'b1, SIZE_BYTE, lfsr_take(32), 1'b1);
        cpu_access(32'hA000_0003 | base, 1'b1, SIZE_BYTE, lfsr_take(32), 1'b1);
        cpu_access(32'hA000_0006 | base, 1'b1, SIZE_HALF, lfsr_take(32), 1'b1);
        cpu_access(32'h8000_0000 | base, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        cpu_access(32'h8000_0001 | base, 1'b0, SIZE_BYTE, 32'h0, 1'b1);
        cpu_access(32'h8000_0003 | base, 1'b0, SIZE_BYTE, 32'h0, 1'b1);
        cpu_access(32'h8000_0002 | base, 1'b0, SIZE_HALF, 32'h0, 1'b1);
        cpu_access(32'h8000_0006 | base, 1'b0, SIZE_HALF, 32'h0, 1'b1);
        finish_test("unmapped kseg0/kseg1", e0);
    endtask

    task automatic test_mapped();
        int     e0;
        vaddr_t off;
        e0  = err_total();
        tlb_write(0, 20'h00010, 20'h00100, 1'b1, 1'b1);
        tlb_write(1, 20'h00011, 20'h00230, 1'b1, 1'b1);
        off = (lfsr_take(10) & 32'h0000_03ff) << 2;     // word inside the page
        cpu_access(32'h0001_0000 | off, 1'b1, SIZE_WORD, lfsr_take(32), 1'b0);
        cpu_access(32'h0001_1000 | off, 1'b1, SIZE_WORD, lfsr_take(32), 1'b0);
        cpu_access(32'h0001_0000 | off, 1'b0, SIZE_WORD, 32'h0, 1'b0);
        cpu_access(32'h0001_1000 | off, 1'b0, SIZE_WORD, 32'h0, 1'b0);
        cpu_access(32'h0001_1001 | off, 1'b0, SIZE_BYTE, 32'h0, 1'b1);
        finish_test("mapped kuseg", e0);
    endtask

    task automatic test_tlb_faults();
        int e0;
        e0 = err_total();
        tlb_write(2, 20'h00020, 20'h00300, 1'b0, 1'b1);  // invalid
        tlb_write(3, 20'h00030, 20'h00400, 1'b1, 1'b0);  // clean
        cpu_access(32'h0005_0010, 1'b0, SIZE_WORD, 32'h0, 1'b0);
        cpu_access(32'h0005_0010, 1'b1, SIZE_WORD, lfsr_take(32), 1'b0);
        cpu_access(32'h0002_0020, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        cpu_access(32'h0002_0020, 1'b1, SIZE_BYTE, lfsr_take(32), 1'b0);
        cpu_access(32'h0003_0030, 1'b1, SIZE_WORD, lfsr_take(32), 1'b0);
        cpu_access(32'h0001_0082, 1'b1, SIZE_HALF, lfsr_take(32), 1'b0);
        cpu_access(32'h0001_0082, 1'b0, SIZE_HALF, 32'h0, 1'b0);
        finish_test("tlb faults", e0);
    endtask

    task automatic test_addr_errors();
        int e0;
        e0 = err_total();
        cpu_access(32'h8000_0301, 1'b1, SIZE_HALF, lfsr_take(32), 1'b1);
        cpu_access(32'h8000_0302, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        cpu_access(32'h0001_0002, 1'b0, SIZE_WORD, 32'h0, 1'b0);
        cpu_access(32'h8000_0300, 1'b0, SIZE_WORD, 32'h0, 1'b0);
        cpu_access(32'h8000_0300, 1'b1, SIZE_WORD, lfsr_take(32), 1'b0);
        cpu_access(32'hC000_0000, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        cpu_access(32'hE000_0004, 1'b1, SIZE_WORD, lfsr_take(32), 1'b1);
        cpu_access(32'h8000_0300, 1'b1, SIZE_WORD, lfsr_take(32), 1'b1);
        cpu_access(32'h8000_0300, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        finish_test("address errors", e0);
    endtask

    initial begin
        int e0;
        lfsr_q        = 32'hda23;
        aresetn       = 1'b0;
        i_req         = 1'b0;
        i_cpu_req     = '0;
        i_kernel_mode = 1'b0;
        i_tlb_we      = 1'b0;
        i_tlb_idx     = '0;
        i_tlb_entry   = '0;
        mem_delay     = 2'd0;
        exp_resp      = '0;
        exp_bus       = '0;
        mem_expected  = 1'b0;
        tlb_set       = '0;
        hi_edges      = 0;
        n_err         = 0;
        n_pass        = 0;
        n_fail        = 0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        e0 = err_total();
        repeat (3) @(posedge aclk);                // request lands inside the stretch
        cpu_access(32'hA000_0040, 1'b1, SIZE_WORD, lfsr_take(32), 1'b1);
        cpu_access(32'h8000_0040, 1'b0, SIZE_WORD, 32'h0, 1'b1);
        finish_test("reset stretch", e0);
        test_unmapped();
        test_mapped();
        test_tlb_faults();
        test_addr_errors();
        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_total());
        if (n_fail == 0 && err_total() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/mmu_pkg.sv
logic/reset_stretch.sv
logic/tlb_lookup.sv
logic/mem_ctrl.sv
logic/bus_master.sv
logic/mmu_top.sv
verif/mem_model.sv
verif/tb_mmu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert --top-module tb_mmu_top -f sim.f -o tb_mmu_top \
    > build.log 2>&1 &&
./obj_dir/tb_mmu_top > sim.log 2>&1
grep -sqx "TEST OK" sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log and build.log"; exit 1; }
